/* rtl/zmem_pkg.sv */
package zmem_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////

	localparam int page_w      = 8;
	localparam int word_addr_w = 21;
	localparam int num_win     = 4;

	// bit 8 of each window entry is the rom flag and bits 7..0 the page
	// window 0 is rom page 0 and windows 1 to 3 are ram pages 5, 2 and 0
	localparam logic [num_win-1:0][page_w:0] reset_pages = {
		9'h000,
		9'h002,
		9'h005,
		9'h100
	};

	//////////////////////////////
	// request and response types
	//////////////////////////////

	typedef struct packed {
		logic [15:0] addr;
		logic        rnw;
		logic [7:0]  wdata;
	} cpu_req_t;

	typedef struct packed {
		logic [1:0]        win;
		logic [page_w-1:0] page;
		logic              rom;
	} page_wr_t;

	// bsel bit 1 is the high byte lane
	typedef struct packed {
		logic [word_addr_w-1:0] addr;
		logic                   rnw;
		logic [15:0]            wdata;
		logic [1:0]             bsel;
	} dram_cmd_t;

	typedef logic [15:0] dram_rd_t;

	// owner of an outstanding read
	typedef logic req_src_t;
	localparam req_src_t src_cpu = 1'b0;
	localparam req_src_t src_vid = 1'b1;

endpackage

/* rtl/window_pager.sv */
`timescale 1ns/1ps

module window_pager
(
	input  logic                                 fclk,
	input  logic                                 rst_n,

	input  zmem_pkg::page_wr_t                   page_wr,
	input  logic                                 page_wr_valid,

	input  logic [15:0]                          cpu_addr,
	output logic [zmem_pkg::word_addr_w-1:0]     word_addr,
	output logic                                 rom
);

	logic [zmem_pkg::num_win-1:0][zmem_pkg::page_w-1:0] pages;
	logic [zmem_pkg::num_win-1:0]                       rom_flags;
	logic [1:0]                                         win;

	//////////////////////////////
	// page registers
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < zmem_pkg::num_win; i++)
			begin
				pages[i]     <= zmem_pkg::reset_pages[i][zmem_pkg::page_w-1:0];
				rom_flags[i] <= zmem_pkg::reset_pages[i][zmem_pkg::page_w];
			end
		end
		else if (page_wr_valid)
		begin
			pages[page_wr.win]     <= page_wr.page;
			rom_flags[page_wr.win] <= page_wr.rom;
		end
	end

	//////////////////////////////
	// translation
	//////////////////////////////

	// top two address bits pick the 16k window
	assign win = cpu_addr[15:14];

	// page, then word offset inside the window
	assign word_addr = {pages[win], cpu_addr[13:1]};
	assign rom       = rom_flags[win];

endmodule

/* rtl/cpu_mem_port.sv */
`timescale 1ns/1ps

module cpu_mem_port
#(
	parameter int depth = 4
)
(
	input  logic                 fclk,
	input  logic                 rst_n,

	input  zmem_pkg::cpu_req_t   cpu_req,
	input  logic                 cpu_req_valid,
	output logic                 cpu_req_ready,

	input  zmem_pkg::page_wr_t   page_wr,
	input  logic                 page_wr_valid,

	output zmem_pkg::dram_cmd_t  cmd,
	output logic                 cmd_valid,
	input  logic                 cmd_ready,

	input  logic                 rd_word_valid,
	input  zmem_pkg::dram_rd_t   rd_word,
	output logic                 cpu_rsp_valid,
	output logic [7:0]           cpu_rsp_data
);

	// one extra slot covers the word sitting in the arbiter output register
	localparam int qd    = depth + 1;
	localparam int cnt_w = $clog2(qd + 1);

	zmem_pkg::cpu_req_t                     req_q;
	logic                                   held;
	logic [zmem_pkg::word_addr_w-1:0]       win_addr;
	logic                                   win_rom;
	logic                                   drop;
	logic                                   cmd_done;

	logic [qd-1:0]                          sel_q;
	logic [qd-1:0]                          sel_next;
	logic [cnt_w-1:0]                       sel_cnt;
	logic [cnt_w-1:0]                       wr_idx;
	logic                                   sel_push;
	logic                                   sel_pop;

	window_pager pager
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.page_wr       (page_wr),
		.page_wr_valid (page_wr_valid),
		.cpu_addr      (req_q.addr),
		.word_addr     (win_addr),
		.rom           (win_rom)
	);

	//////////////////////////////
	// request holding
	//////////////////////////////

	// writes into a rom window vanish here
	assign drop     = held && !req_q.rnw && win_rom;
	assign cmd_done = cmd_valid && cmd_ready;

	assign cpu_req_ready = !held || drop || cmd_done;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			held <= 1'b0;
		else if (cpu_req_valid && cpu_req_ready)
			held <= 1'b1;
		else if (drop || cmd_done)
			held <= 1'b0;
	end

	always_ff @(posedge fclk)
	begin
		if (cpu_req_valid && cpu_req_ready)
			req_q <= cpu_req;
	end

	// word command with the byte copied to both lanes
	assign cmd_valid  = held && !drop;
	assign cmd.addr   = win_addr;
	assign cmd.rnw    = req_q.rnw;
	assign cmd.wdata  = {2{req_q.wdata}};
	assign cmd.bsel   = req_q.addr[0] ? 2'b10 : 2'b01;

	//////////////////////////////
	// byte select queue
	//////////////////////////////

	assign sel_push = cmd_done && req_q.rnw;
	assign sel_pop  = rd_word_valid;

	always_comb
	begin
		sel_next = sel_pop ? (sel_q >> 1) : sel_q;
		wr_idx   = sel_pop ? sel_cnt - 1'b1 : sel_cnt;
		if (sel_push)
			sel_next[wr_idx] = req_q.addr[0];
	end

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			sel_cnt <= '0;
		else
			sel_cnt <= sel_cnt + cnt_w'(sel_push) - cnt_w'(sel_pop);
	end

	always_ff @(posedge fclk)
	begin
		sel_q <= sel_next;
	end

	// oldest read owns the word coming back
	assign cpu_rsp_valid = rd_word_valid;
	assign cpu_rsp_data  = sel_q[0] ? rd_word[15:8] : rd_word[7:0];

endmodule

/* rtl/read_tag_fifo.sv */
`timescale 1ns/1ps

module read_tag_fifo
#(
	parameter int depth = 4
)
(
	input  logic                fclk,
	input  logic                rst_n,

	input  logic                push,
	input  zmem_pkg::req_src_t  tag_in,
	input  logic                pop,

	output zmem_pkg::req_src_t  tag_out,
	output logic                full
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	zmem_pkg::req_src_t  mem [depth];
	logic [ptr_w-1:0]    wr_ptr;
	logic [ptr_w-1:0]    rd_ptr;
	logic [cnt_w-1:0]    cnt;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			cnt <= cnt + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge fclk)
	begin
		if (push)
			mem[wr_ptr] <= tag_in;
	end

	assign tag_out = mem[rd_ptr];
	assign full    = (cnt == cnt_w'(depth));

endmodule

/* rtl/dram_arbiter.sv */
`timescale 1ns/1ps

module dram_arbiter
#(
	parameter int depth = 4
)
(
	input  logic                              fclk,
	input  logic                              rst_n,

	input  logic [zmem_pkg::word_addr_w-1:0]  vid_req_addr,
	input  logic                              vid_req_valid,
	output logic                              vid_req_ready,

	input  zmem_pkg::dram_cmd_t               cpu_cmd,
	input  logic                              cpu_cmd_valid,
	output logic                              cpu_cmd_ready,

	output zmem_pkg::dram_cmd_t               dram_cmd,
	output logic                              dram_cmd_valid,
	input  logic                              dram_cmd_ready,

	input  logic                              dram_rd_valid,
	input  zmem_pkg::dram_rd_t                dram_rd,

	output logic                              vid_rsp_valid,
	output zmem_pkg::dram_rd_t                vid_rsp_data,
	output logic                              cpu_rd_valid,
	output zmem_pkg::dram_rd_t                cpu_rd
);

	logic                 tag_full;
	zmem_pkg::req_src_t   tag_out;
	logic                 hold_q;
	logic                 hold_vid_q;
	logic                 grant_vid;
	logic                 xfer;
	zmem_pkg::dram_rd_t   rd_q;

	//////////////////////////////
	// grant
	//////////////////////////////

	// a stalled command keeps the port so dram_cmd stays stable
	assign grant_vid = hold_q ? hold_vid_q : vid_req_valid;

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			hold_q     <= 1'b0;
			hold_vid_q <= 1'b0;
		end
		else
		begin
			hold_q     <= dram_cmd_valid && !dram_cmd_ready;
			hold_vid_q <= grant_vid;
		end
	end

	always_comb
	begin
		if (grant_vid)
		begin
			dram_cmd.addr  = vid_req_addr;
			dram_cmd.rnw   = 1'b1;
			dram_cmd.wdata = '0;
			dram_cmd.bsel  = 2'b11;
		end
		else
			dram_cmd = cpu_cmd;
	end

	assign dram_cmd_valid = !tag_full && (grant_vid ? vid_req_valid : cpu_cmd_valid);
	assign vid_req_ready  = !tag_full && dram_cmd_ready && !(hold_q && !hold_vid_q);
	assign cpu_cmd_ready  = !tag_full && dram_cmd_ready && !grant_vid;
	assign xfer           = dram_cmd_valid && dram_cmd_ready;

	//////////////////////////////
	// read routing
	//////////////////////////////

	read_tag_fifo #(.depth(depth)) tags
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.push    (xfer && dram_cmd.rnw),
		.tag_in  (grant_vid ? zmem_pkg::src_vid : zmem_pkg::src_cpu),
		.pop     (dram_rd_valid),
		.tag_out (tag_out),
		.full    (tag_full)
	);

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			vid_rsp_valid <= 1'b0;
			cpu_rd_valid  <= 1'b0;
		end
		else
		begin
			vid_rsp_valid <= dram_rd_valid && (tag_out == zmem_pkg::src_vid);
			cpu_rd_valid  <= dram_rd_valid && (tag_out == zmem_pkg::src_cpu);
		end
	end

	always_ff @(posedge fclk)
	begin
		if (dram_rd_valid)
			rd_q <= dram_rd;
	end

	// one word register serves both owners
	assign vid_rsp_data = rd_q;
	assign cpu_rd       = rd_q;

endmodule

/* rtl/zmem_top.sv */
`timescale 1ns/1ps

module zmem_top
#(
	parameter int tag_depth = 4
)
(
	input  logic                              fclk,
	input  logic                              rst_n,

	// cpu side
	input  zmem_pkg::cpu_req_t                cpu_req,
	input  logic                              cpu_req_valid,
	output logic                              cpu_req_ready,
	input  zmem_pkg::page_wr_t                page_wr,
	input  logic                              page_wr_valid,
	output logic                              cpu_rsp_valid,
	output logic [7:0]                        cpu_rsp_data,

	// video fetch
	input  logic [zmem_pkg::word_addr_w-1:0]  vid_req_addr,
	input  logic                              vid_req_valid,
	output logic                              vid_req_ready,
	output logic                              vid_rsp_valid,
	output zmem_pkg::dram_rd_t                vid_rsp_data,

	// dram
	output zmem_pkg::dram_cmd_t               dram_cmd,
	output logic                              dram_cmd_valid,
	input  logic                              dram_cmd_ready,
	input  logic                              dram_rd_valid,
	input  zmem_pkg::dram_rd_t                dram_rd
);

	zmem_pkg::dram_cmd_t  cpu_cmd;
	logic                 cpu_cmd_valid;
	logic                 cpu_cmd_ready;
	logic                 cpu_rd_valid;
	zmem_pkg::dram_rd_t   cpu_rd;

	cpu_mem_port #(.depth(tag_depth)) cpu_port
	(
		.fclk          (fclk),
		.rst_n         (rst_n),
		.cpu_req       (cpu_req),
		.cpu_req_valid (cpu_req_valid),
		.cpu_req_ready (cpu_req_ready),
		.page_wr       (page_wr),
		.page_wr_valid (page_wr_valid),
		.cmd           (cpu_cmd),
		.cmd_valid     (cpu_cmd_valid),
		.cmd_ready     (cpu_cmd_ready),
		.rd_word_valid (cpu_rd_valid),
		.rd_word       (cpu_rd),
		.cpu_rsp_valid (cpu_rsp_valid),
		.cpu_rsp_data  (cpu_rsp_data)
	);

	dram_arbiter #(.depth(tag_depth)) arb
	(
		.fclk           (fclk),
		.rst_n          (rst_n),
		.vid_req_addr   (vid_req_addr),
		.vid_req_valid  (vid_req_valid),
		.vid_req_ready  (vid_req_ready),
		.cpu_cmd        (cpu_cmd),
		.cpu_cmd_valid  (cpu_cmd_valid),
		.cpu_cmd_ready  (cpu_cmd_ready),
		.dram_cmd       (dram_cmd),
		.dram_cmd_valid (dram_cmd_valid),
		.dram_cmd_ready (dram_cmd_ready),
		.dram_rd_valid  (dram_rd_valid),
		.dram_rd        (dram_rd),
		.vid_rsp_valid  (vid_rsp_valid),
		.vid_rsp_data   (vid_rsp_data),
		.cpu_rd_valid   (cpu_rd_valid),
		.cpu_rd         (cpu_rd)
	);

endmodule

/* verif/zmem_tb.sv */
`timescale 1ns/1ps

module zmem_tb;

	localparam int tag_depth  = 4;
	localparam int wait_limit = 2000;

	// video traffic lives in pages f0 and up and cpu pages stay below
	localparam logic [7:0] vid_page = 8'hF0;

	logic                              fclk = 1'b0;
	logic                              rst_n;
	zmem_pkg::cpu_req_t                cpu_req;
	logic                              cpu_req_valid;
	logic                              cpu_req_ready;
	zmem_pkg::page_wr_t                page_wr;
	logic                              page_wr_valid;
	logic                              cpu_rsp_valid;
	logic [7:0]                        cpu_rsp_data;
	logic [zmem_pkg::word_addr_w-1:0]  vid_req_addr;
	logic                              vid_req_valid;
	logic                              vid_req_ready;
	logic                              vid_rsp_valid;
	zmem_pkg::dram_rd_t                vid_rsp_data;
	zmem_pkg::dram_cmd_t               dram_cmd;
	logic                              dram_cmd_valid;
	logic                              dram_cmd_ready = 1'b1;
	logic                              dram_rd_valid = 1'b0;
	zmem_pkg::dram_rd_t                dram_rd = '0;

	int           cycle = 0;
	int           errors = 0;
	int           checks = 0;
	int           tests_run = 0;
	int           tests_bad = 0;
	bit           hung = 1'b0;
	logic [31:0]  rng = 32'h6499;
	// cpu stimulus draws from its own stream
	logic [31:0]  stim_rng = 32'h6499;
	bit           stall_mode = 1'b0;
	int           stall_left = 0;

	// memory model and expected traffic
	zmem_pkg::dram_rd_t   mem [int];
	zmem_pkg::dram_rd_t   rd_data [$];
	int                   rd_due [$];
	zmem_pkg::dram_cmd_t  cpu_exp_cmd [$];
	logic [20:0]          vid_exp_addr [$];
	logic [7:0]           cpu_exp_byte [$];
	zmem_pkg::dram_rd_t   vid_exp_word [$];
	logic [7:0]           tb_page [4];
	logic                 tb_rom [4];
	bit                   stalled = 1'b0;
	zmem_pkg::dram_cmd_t  stalled_cmd;

	zmem_top #(.tag_depth(tag_depth)) DUT (.*);

	always #5 fclk = ~fclk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// words never written take a pattern of every address bit
	function automatic zmem_pkg::dram_rd_t fill_word(input logic [20:0] a);
		return a[15:0] ^ {a[4:0], a[20:16], 6'h2d} ^ 16'h9c35;
	endfunction

	function automatic zmem_pkg::dram_rd_t mem_word(input logic [20:0] a);
		if (mem.exists(int'(a)))
			return mem[int'(a)];
		return fill_word(a);
	endfunction

	function automatic logic [20:0] map_addr(input logic [15:0] a);
		return {tb_page[a[15:14]], a[13:1]};
	endfunction

	function automatic bit busy();
		return cpu_exp_cmd.size() != 0 || vid_exp_addr.size() != 0 ||
			cpu_exp_byte.size() != 0 || vid_exp_word.size() != 0 || rd_data.size() != 0;
	endfunction

	task automatic report_hang(input string what);
		errors++;
		hung = 1'b1;
		$display("timeout at %0t: %s", $time, what);
	endtask

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_flag(input logic exp, input logic got, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t: %s expected %b got %b", $time, what, exp, got);
		end
	endtask

	task automatic check_byte(input logic [7:0] exp, input logic [7:0] got, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_word(input zmem_pkg::dram_rd_t exp, input zmem_pkg::dram_rd_t got,
		input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, what, exp, got);
		end
	endtask

	// lanes off compares address and direction only
	task automatic check_cmd(input zmem_pkg::dram_cmd_t exp, input zmem_pkg::dram_cmd_t got,
		input logic lanes, input string what);
		logic bad;
		checks++;
		bad = (got.addr !== exp.addr) || (got.rnw !== exp.rnw);
		if (lanes && got.bsel !== exp.bsel)
			bad = 1'b1;
		if (lanes && !exp.rnw && got.wdata !== exp.wdata)
			bad = 1'b1;
		if (bad)
		begin
			errors++;
			$display("[FAIL] %0t: %s expected addr %h rnw %b wdata %h bsel %b", $time, what,
				exp.addr, exp.rnw, exp.wdata, exp.bsel);
			$display("       got addr %h rnw %b wdata %h bsel %b",
				got.addr, got.rnw, got.wdata, got.bsel);
		end
	endtask

	//////////////////////////////
	// memory model and monitor
	//////////////////////////////

	task automatic take_command(input zmem_pkg::dram_cmd_t cmd);
		zmem_pkg::dram_cmd_t exp;
		zmem_pkg::dram_rd_t  word;
		exp  = '0;
		word = mem_word(cmd.addr);
		if (cmd.addr[20:13] >= vid_page)
		begin
			if (vid_exp_addr.size() == 0)
			begin
				errors++;
				$display("video command at %0t with no video request pending", $time);
			end
			else
			begin
				exp.addr = vid_exp_addr.pop_front();
				exp.rnw  = 1'b1;
				check_cmd(exp, cmd, 1'b0, "video dram_cmd");
				vid_exp_word.push_back(word);
			end
		end
		else if (cpu_exp_cmd.size() == 0)
		begin
			errors++;
			$display("cpu command at %0t with no cpu request pending", $time);
		end
		else
		begin
			exp = cpu_exp_cmd.pop_front();
			check_cmd(exp, cmd, 1'b1, "cpu dram_cmd");
			if (exp.rnw)
				cpu_exp_byte.push_back(exp.bsel[1] ? word[15:8] : word[7:0]);
		end
		if (cmd.rnw)
		begin
			rd_data.push_back(word);
			rd_due.push_back(cycle + 2 + int'(next_rand() & 32'h7));
		end
		else
		begin
			if (cmd.bsel[1])
				word[15:8] = cmd.wdata[15:8];
			if (cmd.bsel[0])
				word[7:0] = cmd.wdata[7:0];
			mem[int'(cmd.addr)] = word;
		end
	endtask

	initial
	begin : memory_model
		logic [31:0] r;
		forever
		begin
			@(posedge fclk);
			cycle = cycle + 1;
			if (stall_left > 0)
				stall_left = stall_left - 1;
			else if (stall_mode)
			begin
				r = next_rand();
				if (r[2:0] == 3'd0)
					stall_left = 1 + int'(r[4:3]);
			end
			dram_cmd_ready <= (stall_left == 0);
			// reads return in order and at most one word per cycle
			if (rd_data.size() > 0 && rd_due[0] <= cycle)
			begin
				dram_rd_valid <= 1'b1;
				dram_rd       <= rd_data.pop_front();
				rd_due.delete(0);
			end
			else
				dram_rd_valid <= 1'b0;
		end
	end

	initial
	begin : bus_monitor
		forever
		begin
			@(negedge fclk);
			if (rst_n)
			begin
				if (stalled)
				begin
					check_flag(1'b1, dram_cmd_valid, "stalled dram_cmd_valid");
					check_cmd(stalled_cmd, dram_cmd, 1'b1, "stalled dram_cmd");
				end
				stalled     = dram_cmd_valid && !dram_cmd_ready;
				stalled_cmd = dram_cmd;
				if (dram_cmd_valid && dram_cmd_ready)
					take_command(dram_cmd);
				if (cpu_rsp_valid && cpu_exp_byte.size() == 0)
				begin
					errors++;
					$display("cpu response at %0t with no cpu read outstanding", $time);
				end
				else if (cpu_rsp_valid)
					check_byte(cpu_exp_byte.pop_front(), cpu_rsp_data, "cpu read byte");
				if (vid_rsp_valid && vid_exp_word.size() == 0)
				begin
					errors++;
					$display("video response at %0t with no video read outstanding", $time);
				end
				else if (vid_rsp_valid)
					check_word(vid_exp_word.pop_front(), vid_rsp_data, "video read word");
			end
		end
	end

	//////////////////////////////
	// drivers
	//////////////////////////////

	task automatic cpu_access(input logic [15:0] addr, input logic rnw, input logic [7:0] wdata);
		zmem_pkg::cpu_req_t  req;
		zmem_pkg::dram_cmd_t exp;
		int                  n;
		if (hung)
			return;
		req.addr   = addr;
		req.rnw    = rnw;
		req.wdata  = wdata;
		exp.addr   = map_addr(addr);
		exp.rnw    = rnw;
		exp.wdata  = {wdata, wdata};
		exp.bsel   = addr[0] ? 2'b10 : 2'b01;
		@(posedge fclk);
		cpu_req       <= req;
		cpu_req_valid <= 1'b1;
		n = 0;
		@(negedge fclk);
		while (!cpu_req_ready && n < wait_limit)
		begin
			@(negedge fclk);
			n++;
		end
		if (!cpu_req_ready)
			report_hang("cpu request never accepted");
		else if (rnw || !tb_rom[addr[15:14]])
			cpu_exp_cmd.push_back(exp);
		@(posedge fclk);
		cpu_req_valid <= 1'b0;
	endtask

	// back to back video reads three words apart
	task automatic vid_burst(input logic [20:0] base, input int count);
		int n;
		if (hung)
			return;
		for (int i = 0; i < count; i++)
		begin
			@(posedge fclk);
			vid_req_addr  <= base + 21'(i * 3);
			vid_req_valid <= 1'b1;
			// a video request reaches dram_cmd within the same cycle
			vid_exp_addr.push_back(base + 21'(i * 3));
			n = 0;
			@(negedge fclk);
			while (!vid_req_ready && n < wait_limit)
			begin
				@(negedge fclk);
				n++;
			end
			if (!vid_req_ready)
			begin
				report_hang("video request never accepted");
				break;
			end
		end
		@(posedge fclk);
		vid_req_valid <= 1'b0;
	endtask

	task automatic cpu_random(input int count, input bit with_writes);
		logic [31:0] r;
		for (int i = 0; i < count; i++)
		begin
			stim_rng = xorshift(stim_rng);
			r = stim_rng;
			cpu_access(r[15:0], !with_writes || r[16], r[31:24]);
		end
	endtask

	task automatic set_page(input logic [1:0] win, input logic [7:0] page, input logic rom);
		zmem_pkg::page_wr_t pw;
		pw.win  = win;
		pw.page = page;
		pw.rom  = rom;
		@(posedge fclk);
		page_wr       <= pw;
		page_wr_valid <= 1'b1;
		@(posedge fclk);
		page_wr_valid <= 1'b0;
		tb_page[win] = page;
		tb_rom[win]  = rom;
	endtask

	task automatic drain();
		int n;
		if (hung)
			return;
		n = 0;
		while (busy() && n < wait_limit)
		begin
			@(negedge fclk);
			n++;
		end
		if (busy())
			report_hang("outstanding traffic did not drain");
		repeat (4) @(negedge fclk);
	endtask

	task automatic end_test(input string name, input int e0);
		tests_run++;
		if (errors != e0)
		begin
			tests_bad++;
			$display("test %s: %0d errors", name, errors - e0);
		end
		else
			$display("test %s: ok", name);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_reset_map();
		int e0;
		e0 = errors;
		@(negedge fclk);
		check_flag(1'b1, cpu_req_ready, "cpu_req_ready after reset");
		check_flag(1'b1, vid_req_ready, "vid_req_ready after reset");
		check_flag(1'b0, dram_cmd_valid, "dram_cmd_valid after reset");
		check_flag(1'b0, cpu_rsp_valid, "cpu_rsp_valid after reset");
		check_flag(1'b0, vid_rsp_valid, "vid_rsp_valid after reset");
		cpu_access(16'h4002, 1'b1, 8'h00);
		cpu_access(16'h0000, 1'b1, 8'h00);
		drain();
		end_test("reset mapping", e0);
	endtask

	task automatic test_page_remap();
		int e0;
		e0 = errors;
		set_page(2'd3, 8'h1A, 1'b0);
		cpu_access(16'hC005, 1'b0, 8'h5C);
		cpu_access(16'hC005, 1'b1, 8'h00);
		cpu_access(16'hC004, 1'b1, 8'h00);
		drain();
		end_test("page remap", e0);
	endtask

	task automatic test_byte_reads();
		int e0;
		e0 = errors;
		cpu_access(16'h8010, 1'b0, 8'hA5);
		cpu_access(16'h8011, 1'b0, 8'h5A);
		cpu_access(16'h8010, 1'b1, 8'h00);
		cpu_access(16'h8011, 1'b1, 8'h00);
		stall_mode = 1'b1;
		cpu_random(16, 1'b0);
		stall_mode = 1'b0;
		drain();
		end_test("byte reads", e0);
	endtask

	task automatic test_rom_drop();
		int e0;
		e0 = errors;
		// window 0 is rom so the write vanishes and the read comes next
		cpu_access(16'h0010, 1'b0, 8'h77);
		cpu_access(16'h0010, 1'b1, 8'h00);
		drain();
		set_page(2'd0, 8'h00, 1'b0);
		cpu_access(16'h0010, 1'b0, 8'h77);
		cpu_access(16'h0010, 1'b1, 8'h00);
		drain();
		end_test("rom write drop", e0);
	endtask

	task automatic test_video();
		int e0;
		e0 = errors;
		vid_burst({8'hF3, 13'h0100}, 8);
		drain();
		end_test("video path", e0);
	endtask

	task automatic test_mixed();
		int e0;
		e0 = errors;
		stall_mode = 1'b1;
		fork
			vid_burst({8'hF8, 13'h0000}, 12);
			cpu_random(12, 1'b1);
		join
		stall_mode = 1'b0;
		drain();
		end_test("mixed traffic", e0);
	endtask

	initial
	begin
		rst_n         = 1'b0;
		cpu_req       = '0;
		cpu_req_valid = 1'b0;
		page_wr       = '0;
		page_wr_valid = 1'b0;
		vid_req_addr  = '0;
		vid_req_valid = 1'b0;
		tb_page = '{8'h00, 8'h05, 8'h02, 8'h00};
		tb_rom  = '{1'b1, 1'b0, 1'b0, 1'b0};
		repeat (16) @(posedge fclk);
		rst_n <= 1'b1;
		test_reset_map();
		test_page_remap();
		test_byte_reads();
		test_rom_drop();
		test_video();
		test_mixed();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_bad, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* compile.f */
rtl/zmem_pkg.sv
rtl/window_pager.sv
rtl/cpu_mem_port.sv
rtl/read_tag_fifo.sv
rtl/dram_arbiter.sv
rtl/zmem_top.sv
verif/zmem_tb.sv

/* run.sh */
#!/bin/sh
# build and run the zmem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	--top-module zmem_tb -Mdir obj_dir -f compile.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vzmem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
